//--- bench/ssp21_responder_sva.sv
module ssp21_responder_sva (
	input logic                   clk,
	input logic                   arst_n,
	input ssp21_pkg::udp_tx_bus_t udp_tx,
	input logic                   reply_req,
	input logic                   error_req,
	input logic                   reply_grant,
	input logic                   error_grant
);

	//////////////////////////////////////////////////
	// Frame tracking, open from start to commit

	logic in_frame;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			in_frame <= 1'b0;
		else if (udp_tx.start)
			in_frame <= 1'b1;
		else if (udp_tx.commit)
			in_frame <= 1'b0;
	end

	data_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
		udp_tx.data_valid |-> in_frame)
		else $error("tx data word outside a frame");

	// Commit closes an open frame, never in a start cycle
	start_commit_apart: assert property (@(posedge clk) disable iff (!arst_n)
		udp_tx.commit |-> in_frame && !udp_tx.start)
		else $error("tx commit outside a frame or together with start");

	// One owner per frame, and that owner still requests the bus
	one_grant: assert property (@(posedge clk) disable iff (!arst_n)
		(reply_grant || error_grant) |->
			$onehot({reply_grant && reply_req, error_grant && error_req}))
		else $error("bus granted to both writers or to an idle writer");

endmodule

bind udp_tx_arbiter ssp21_responder_sva sva_i (
	.clk         (clk),
	.arst_n      (arst_n),
	.udp_tx      (udp_tx),
	.reply_req   (reply_req),
	.error_req   (error_req),
	.reply_grant (reply_grant),
	.error_grant (error_grant)
);

//--- bench/ssp21_responder_tb.sv
module ssp21_responder_tb;
	import ssp21_pkg::*;

	localparam int           NUM_REQ      = 250;
	localparam max_nonce_t   NONCE_CEIL   = 16'd1000;
	localparam session_dur_t SESSION_CEIL = 32'd600000;

	logic                  clk;
	logic                  arst_n;
	ssp21_handshake_mode_t handshake_mode;
	udp_rx_bus_t           udp_rx;
	udp_tx_bus_t           udp_tx;

	// Request words, one spare for over-long frames
	word_t frame_w [0:12];

	// Expected replies, one entry per frame and per word
	int              exp_count [$];
	ssp21_function_t exp_func [$];
	word_t           exp_words [$];
	bytes_valid_t    exp_bytes [$];
	session_id_t     next_id = '0;
	int              replies_expected = 0;
	int              replies_seen = 0;

	// Monitor state
	logic            in_frame = 1'b0;
	int              cur_len = 0;
	int              words_seen = 0;
	ssp21_function_t cur_func;

	ssp21_responder #(
		.MAX_NONCE_LIMIT   (NONCE_CEIL),
		.MAX_SESSION_LIMIT (SESSION_CEIL)
	) ssp21_responder_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.handshake_mode (handshake_mode),
		.udp_rx         (udp_rx),
		.udp_tx         (udp_tx)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Each request takes at most 22 cycles including the gap
	initial begin
		repeat (NUM_REQ * 24 + 100) @(posedge clk);
		$display("Error: timeout, %0d of %0d replies went missing",
			replies_expected - replies_seen, replies_expected);
		abort_run();
	end

	//////////////////////////////////////////////////
	// Failure and compare tasks

	task automatic abort_run;
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic compare_function(input string name, input ssp21_function_t act,
		input ssp21_function_t exp);
		if (act !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
			abort_run();
		end
	endtask

	task automatic compare_word(input string name, input word_t act, input word_t exp);
		if (act !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
			abort_run();
		end
	endtask

	task automatic compare_bytes(input string name, input bytes_valid_t act,
		input bytes_valid_t exp);
		if (act !== exp) begin
			$display("FAILED at %0t: %s = %0d, expected %0d", $time, name, act, exp);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers

	function automatic logic [7:0] rand_byte(input int hi, input int lo);
		logic [31:0] v;
		v = $urandom_range(hi, lo);
		return v[7:0];
	endfunction

	// Request that passes every check under the current mode
	task automatic make_request(output hs_request_t r);
		r.version        = SSP21_VERSION;
		r.handshake_mode = handshake_mode;
		r.ephemeral_mode = (handshake_mode == SHARED_SECRET) ? NONCE : X25519;
		r.hash           = SHA256;
		r.kdf            = HKDF_SHA256;
		r.nonce_mode     = ssp21_nonce_mode_t'(rand_byte(1, 0));
		r.session_mode   = ssp21_session_mode_t'(rand_byte(1, 0));
		// Ranges straddle the ceilings
		r.max_nonce      = max_nonce_t'($urandom_range(2000, 0));
		r.max_session    = $urandom_range(1200000, 0);
	endtask

	task automatic corrupt_field(inout hs_request_t r);
		case ($urandom_range(6, 0))
			0: r.version = version_t'($urandom_range(65535, 1));
			1: r.handshake_mode = ssp21_handshake_mode_t'(r.handshake_mode + rand_byte(255, 1));
			2: r.ephemeral_mode = ssp21_ephemeral_mode_t'(r.ephemeral_mode + rand_byte(255, 1));
			3: r.hash = ssp21_hash_t'(rand_byte(255, 1));
			4: r.kdf = ssp21_kdf_t'(rand_byte(255, 1));
			5: r.nonce_mode = ssp21_nonce_mode_t'(rand_byte(255, 2));
			default: r.session_mode = ssp21_session_mode_t'(rand_byte(255, 2));
		endcase
	endtask

	task automatic build_frame(input hs_request_t r, input logic [7:0] fn);
		int i;
		frame_w[0] = {fn, r.version, r.ephemeral_mode};
		frame_w[1] = {r.hash, r.kdf, r.nonce_mode, r.session_mode};
		frame_w[2] = {r.max_nonce, r.max_session[31:16]};
		frame_w[3] = {r.max_session[15:0], r.handshake_mode, rand_byte(255, 0)};
		// Ephemeral bytes are only counted by the DUT
		for (i = 4; i < 13; i++)
			frame_w[i] = $urandom();
	endtask

	// Start strobe, len words, then commit or drop
	task automatic drive_frame(input int len, input logic drop_end);
		int i;
		@(negedge clk);
		udp_rx.start = 1'b1;
		for (i = 0; i < len; i++) begin
			@(negedge clk);
			udp_rx.start       = 1'b0;
			udp_rx.data_valid  = 1'b1;
			udp_rx.data        = frame_w[i];
			udp_rx.bytes_valid = (i == 11) ? 3'd3 : 3'd4;
		end
		@(negedge clk);
		udp_rx.start      = 1'b0;
		udp_rx.data_valid = 1'b0;
		udp_rx.commit     = !drop_end;
		udp_rx.drop       = drop_end;
		@(negedge clk);
		udp_rx.commit = 1'b0;
		udp_rx.drop   = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Reference model

	// First failing check in the responder's order
	function automatic ssp21_error_t expected_error(input hs_request_t r,
		input ssp21_handshake_mode_t mode);
		ssp21_ephemeral_mode_t eph;
		eph = (r.handshake_mode == SHARED_SECRET) ? NONCE : X25519;
		if (r.version != 16'd0)
			return UNSUPPORTED_VERSION;
		if (r.handshake_mode != mode)
			return UNSUPPORTED_HANDSHAKE_MODE;
		if (r.ephemeral_mode != eph)
			return UNSUPPORTED_EPHEMERAL;
		if (r.hash != SHA256)
			return UNSUPPORTED_HASH;
		if (r.kdf != HKDF_SHA256)
			return UNSUPPORTED_KDF;
		if (r.nonce_mode > GREATER_THAN_LAST_RX)
			return UNSUPPORTED_NONCE_MODE;
		if (r.session_mode > AES_256_GCM)
			return UNSUPPORTED_SESSION_MODE;
		return NO_ERROR;
	endfunction

	task automatic queue_reply(input hs_request_t r);
		ssp21_error_t code;
		max_nonce_t   nonce;
		session_dur_t dur;
		code = expected_error(r, handshake_mode);
		replies_expected++;
		if (code == NO_ERROR) begin
			nonce = (r.max_nonce < NONCE_CEIL) ? r.max_nonce : NONCE_CEIL;
			dur   = (r.max_session < SESSION_CEIL) ? r.max_session : SESSION_CEIL;
			exp_count.push_back(4);
			exp_func.push_back(REPLY_HANDSHAKE_BEGIN);
			exp_words.push_back({REPLY_HANDSHAKE_BEGIN, r.version, r.handshake_mode});
			exp_words.push_back(next_id);
			exp_words.push_back(dur);
			exp_words.push_back({nonce, 16'h0000});
			exp_bytes.push_back(3'd4);
			exp_bytes.push_back(3'd4);
			exp_bytes.push_back(3'd4);
			exp_bytes.push_back(3'd2);
			// Id moves only on accepted requests
			next_id = next_id + 32'd1;
		end else begin
			exp_count.push_back(1);
			exp_func.push_back(REPLY_HANDSHAKE_ERROR);
			exp_words.push_back({REPLY_HANDSHAKE_ERROR, code, 16'h0000});
			exp_bytes.push_back(3'd2);
		end
	endtask

	//////////////////////////////////////////////////
	// Reply monitor, sampled away from the active edge

	always @(negedge clk) begin
		if (arst_n) begin
			if (udp_tx.start) begin
				if (in_frame) begin
					$display("Error at %0t: reply frame started inside another", $time);
					abort_run();
				end
				if (exp_count.size() == 0) begin
					$display("Error at %0t: reply frame sent with no reply pending", $time);
					abort_run();
				end
				cur_len    = exp_count.pop_front();
				cur_func   = exp_func.pop_front();
				words_seen = 0;
				in_frame   = 1'b1;
			end else if (udp_tx.data_valid) begin
				if (!in_frame || words_seen >= cur_len) begin
					$display("Error at %0t: reply word outside an open frame", $time);
					abort_run();
				end
				if (words_seen == 0)
					compare_function("reply function", ssp21_function_t'(udp_tx.data[31:24]),
						cur_func);
				compare_word("udp_tx.data", udp_tx.data, exp_words.pop_front());
				compare_bytes("udp_tx.bytes_valid", udp_tx.bytes_valid, exp_bytes.pop_front());
				words_seen++;
			end else if (udp_tx.commit) begin
				if (!in_frame) begin
					$display("Error at %0t: commit with no open reply frame", $time);
					abort_run();
				end
				if (words_seen != cur_len) begin
					$display("FAILED at %0t: reply word count = %0d, expected %0d",
						$time, words_seen, cur_len);
					abort_run();
				end
				in_frame = 1'b0;
				replies_seen++;
			end else if (in_frame) begin
				$display("Error at %0t: idle cycle inside a reply frame", $time);
				abort_run();
			end
		end
	end

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		hs_request_t r;
		int          n;
		int          kind;
		void'($urandom(32'h9a56ab65));
		udp_rx         = '0;
		handshake_mode = SHARED_SECRET;
		arst_n         = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		repeat (4) @(negedge clk);

		for (n = 0; n < NUM_REQ; n++) begin
			// Mode only changes between frames
			if (rand_byte(7, 0) == 8'd0)
				handshake_mode = ssp21_handshake_mode_t'(rand_byte(3, 0));
			make_request(r);
			kind = $urandom_range(9, 0);
			if (kind == 4 || kind == 5) begin
				corrupt_field(r);
				if (rand_byte(3, 0) == 8'd0)
					corrupt_field(r);
			end
			build_frame(r, (kind == 9) ? rand_byte(255, 1) : REQUEST_HANDSHAKE_BEGIN);
			case (kind)
				6: drive_frame($urandom_range(11, 1), 1'b0);
				7: drive_frame(13, 1'b0);
				8: drive_frame(12, 1'b1);
				9: drive_frame(12, 1'b0);
				default: begin
					queue_reply(r);
					drive_frame(12, 1'b0);
				end
			endcase
			// Let the verdict settle before the mode may move
			repeat (3 + $urandom_range(3, 0)) @(negedge clk);
		end

		while (replies_seen < replies_expected)
			@(negedge clk);
		// Quiet window for any stray frame
		repeat (40) @(negedge clk);
		if (exp_count.size() != 0 || in_frame) begin
			$display("Error: %0d expected reply frames never completed", exp_count.size());
			abort_run();
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

//--- design/ssp21_error_writer.sv
module ssp21_error_writer (
	input  logic                    clk,
	input  logic                    arst_n,
	input  ssp21_pkg::ssp21_error_t error_code,
	input  logic                    refuse,
	input  logic                    grant,
	output logic                    bus_req,
	output ssp21_pkg::tx_word_t     tx_word
);
	import ssp21_pkg::*;

	ssp21_error_t code_q;

	always_ff @(posedge clk) begin
		if (refuse)
			code_q <= error_code;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus_req <= 1'b0;
			tx_word <= '0;
		end else begin
			tx_word.valid <= 1'b0;
			tx_word.last  <= 1'b0;
			if (refuse)
				bus_req <= 1'b1;
			else if (tx_word.valid)
				bus_req <= 1'b0;
			else if (grant && bus_req) begin
				// Single word frame, function and code in the top two bytes
				tx_word.valid       <= 1'b1;
				tx_word.last        <= 1'b1;
				tx_word.bytes_valid <= 3'd2;
				tx_word.data        <= {REPLY_HANDSHAKE_ERROR, code_q, 16'h0000};
			end
		end
	end

endmodule

//--- design/ssp21_pkg.sv
package ssp21_pkg;

	//////////////////////////////////////////////////
	// Width types

	// One word of the UDP socket bus
	typedef logic [31:0] word_t;
	// Valid bytes in a word, MSB first, 1 to 4
	typedef logic [2:0]  bytes_valid_t;
	typedef logic [15:0] version_t;
	typedef logic [15:0] max_nonce_t;
	// Session duration in ms
	typedef logic [31:0] session_dur_t;
	typedef logic [31:0] session_id_t;

	// The only version this responder speaks
	localparam version_t SSP21_VERSION = 16'd0;

	//////////////////////////////////////////////////
	// Protocol enums, one byte each on the wire

	typedef enum logic [7:0] {
		REQUEST_HANDSHAKE_BEGIN = 8'd0,
		REPLY_HANDSHAKE_BEGIN   = 8'd1,
		REPLY_HANDSHAKE_ERROR   = 8'd2
	} ssp21_function_t;

	typedef enum logic [7:0] {
		SHARED_SECRET   = 8'd0,
		QKD_KEY         = 8'd1,
		PRESHARED_DH    = 8'd2,
		INDUSTRIAL_CERT = 8'd3
	} ssp21_handshake_mode_t;

	typedef enum logic [7:0] {
		X25519 = 8'd0,
		NONCE  = 8'd1,
		NONE   = 8'd2
	} ssp21_ephemeral_mode_t;

	typedef enum logic [7:0] {
		SHA256 = 8'd0
	} ssp21_hash_t;

	typedef enum logic [7:0] {
		HKDF_SHA256 = 8'd0
	} ssp21_kdf_t;

	typedef enum logic [7:0] {
		INCREMENT_LAST_RX    = 8'd0,
		GREATER_THAN_LAST_RX = 8'd1
	} ssp21_nonce_mode_t;

	typedef enum logic [7:0] {
		HMAC_SHA256_16 = 8'd0,
		AES_256_GCM    = 8'd1
	} ssp21_session_mode_t;

	// Code 1 is not used by the handshake
	typedef enum logic [7:0] {
		NO_ERROR                   = 8'd0,
		UNSUPPORTED_VERSION        = 8'd2,
		UNSUPPORTED_EPHEMERAL      = 8'd3,
		UNSUPPORTED_HASH           = 8'd4,
		UNSUPPORTED_KDF            = 8'd5,
		UNSUPPORTED_SESSION_MODE   = 8'd6,
		UNSUPPORTED_NONCE_MODE     = 8'd7,
		UNSUPPORTED_HANDSHAKE_MODE = 8'd8
	} ssp21_error_t;

	//////////////////////////////////////////////////
	// Bus structs

	typedef struct packed {
		logic         start;
		logic         data_valid;
		bytes_valid_t bytes_valid;
		word_t        data;
		logic         commit;
		logic         drop;
	} udp_rx_bus_t;

	typedef struct packed {
		logic         start;
		logic         data_valid;
		bytes_valid_t bytes_valid;
		word_t        data;
		logic         commit;
	} udp_tx_bus_t;

	// Writer to arbiter word
	typedef struct packed {
		logic         valid;
		bytes_valid_t bytes_valid;
		word_t        data;
		logic         last;
	} tx_word_t;

	//////////////////////////////////////////////////
	// Request and session records

	// Parsed Request-Handshake-Begin, ephemeral bytes not kept
	typedef struct packed {
		version_t              version;
		ssp21_ephemeral_mode_t ephemeral_mode;
		ssp21_hash_t           hash;
		ssp21_kdf_t            kdf;
		ssp21_nonce_mode_t     nonce_mode;
		ssp21_session_mode_t   session_mode;
		max_nonce_t            max_nonce;
		session_dur_t          max_session;
		ssp21_handshake_mode_t handshake_mode;
	} hs_request_t;

	// Negotiated result of an accepted request
	typedef struct packed {
		version_t              version;
		ssp21_handshake_mode_t handshake_mode;
		max_nonce_t            max_nonce;
		session_dur_t          max_session;
	} hs_session_t;

endpackage

//--- design/ssp21_reply_writer.sv
module ssp21_reply_writer (
	input  logic                   clk,
	input  logic                   arst_n,
	input  ssp21_pkg::hs_session_t session,
	input  logic                   accept,
	input  logic                   grant,
	output logic                   bus_req,
	output ssp21_pkg::tx_word_t    tx_word
);
	import ssp21_pkg::*;

	hs_session_t session_q;
	session_id_t session_id;
	logic [1:0]  word_idx;
	logic        send;

	// Stream words while the bus is ours
	assign send = grant && bus_req;

	always_ff @(posedge clk) begin
		if (accept)
			session_q <= session;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus_req    <= 1'b0;
			word_idx   <= '0;
			session_id <= '0;
			tx_word    <= '0;
		end else begin
			tx_word.valid <= 1'b0;
			tx_word.last  <= 1'b0;
			if (accept) begin
				bus_req  <= 1'b1;
				word_idx <= '0;
			end else if (tx_word.valid && tx_word.last) begin
				// Frame handed over, next session gets a fresh id
				bus_req    <= 1'b0;
				session_id <= session_id + 32'd1;
			end else if (send) begin
				tx_word.valid       <= 1'b1;
				tx_word.bytes_valid <= 3'd4;
				tx_word.last        <= (word_idx == 2'd3);
				word_idx            <= word_idx + 2'd1;
				case (word_idx)
					2'd0: tx_word.data <= {REPLY_HANDSHAKE_BEGIN, session_q.version,
						session_q.handshake_mode};
					2'd1: tx_word.data <= session_id;
					2'd2: tx_word.data <= session_q.max_session;
					default: begin
						// Nonce limit fills the upper half only
						tx_word.data        <= {session_q.max_nonce, 16'h0000};
						tx_word.bytes_valid <= 3'd2;
					end
				endcase
			end
		end
	end

endmodule

//--- design/ssp21_request_checker.sv
module ssp21_request_checker #(
	parameter ssp21_pkg::max_nonce_t   MAX_NONCE_LIMIT   = 16'hffff,
	parameter ssp21_pkg::session_dur_t MAX_SESSION_LIMIT = 32'hffff_ffff
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  ssp21_pkg::ssp21_handshake_mode_t handshake_mode,
	input  ssp21_pkg::hs_request_t           req,
	input  logic                             req_valid,
	output ssp21_pkg::hs_session_t           session,
	output logic                             accept,
	output logic                             refuse,
	output ssp21_pkg::ssp21_error_t          error_code
);
	import ssp21_pkg::*;

	ssp21_error_t          check;
	ssp21_ephemeral_mode_t eph_expected;
	max_nonce_t            nonce_grant;
	session_dur_t          session_grant;

	// Shared secret mode exchanges nonces, all others use X25519 keys
	assign eph_expected = (req.handshake_mode == SHARED_SECRET) ? NONCE : X25519;

	//////////////////////////////////////////////////
	// First failing check wins

	always_comb begin
		if (req.version != SSP21_VERSION)
			check = UNSUPPORTED_VERSION;
		else if (req.handshake_mode != handshake_mode)
			check = UNSUPPORTED_HANDSHAKE_MODE;
		else if (req.ephemeral_mode != eph_expected)
			check = UNSUPPORTED_EPHEMERAL;
		else if (req.hash != SHA256)
			check = UNSUPPORTED_HASH;
		else if (req.kdf != HKDF_SHA256)
			check = UNSUPPORTED_KDF;
		else if (!(req.nonce_mode inside {INCREMENT_LAST_RX, GREATER_THAN_LAST_RX}))
			check = UNSUPPORTED_NONCE_MODE;
		else if (!(req.session_mode inside {HMAC_SHA256_16, AES_256_GCM}))
			check = UNSUPPORTED_SESSION_MODE;
		else
			check = NO_ERROR;
	end

	// Limits clamp to the local ceilings
	assign nonce_grant   = (req.max_nonce < MAX_NONCE_LIMIT) ? req.max_nonce : MAX_NONCE_LIMIT;
	assign session_grant = (req.max_session < MAX_SESSION_LIMIT) ?
		req.max_session : MAX_SESSION_LIMIT;

	//////////////////////////////////////////////////
	// Registered verdict

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			accept <= 1'b0;
			refuse <= 1'b0;
		end else begin
			accept <= req_valid && (check == NO_ERROR);
			refuse <= req_valid && (check != NO_ERROR);
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			error_code             <= check;
			session.version        <= req.version;
			session.handshake_mode <= req.handshake_mode;
			session.max_nonce      <= nonce_grant;
			session.max_session    <= session_grant;
		end
	end

endmodule

//--- design/ssp21_request_parser.sv
module ssp21_request_parser (
	input  logic                   clk,
	input  logic                   arst_n,
	input  ssp21_pkg::udp_rx_bus_t udp_rx,
	output ssp21_pkg::hs_request_t req,
	output logic                   req_valid
);
	import ssp21_pkg::*;

	// Ephemeral field spans words 4 to 11
	localparam logic [2:0] LAST_EPH_WORD = 3'd7;

	typedef enum logic [2:0] {
		IDLE,
		FIRST,
		SPEC,
		LIMITS,
		MODE,
		EPHEMERAL,
		DONE,
		DROP
	} state_t;

	state_t     state;
	logic [2:0] eph_count;
	logic       full_word;

	// Header words always carry four bytes
	assign full_word = (udp_rx.bytes_valid == 3'd4);

	//////////////////////////////////////////////////
	// Frame state machine

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			eph_count <= '0;
			req_valid <= 1'b0;
		end else begin
			req_valid <= 1'b0;
			case (state)
				IDLE:
					if (udp_rx.start)
						state <= FIRST;
				FIRST:
					if (udp_rx.data_valid) begin
						// Only handshake requests are served here
						if (!full_word || udp_rx.data[31:24] != REQUEST_HANDSHAKE_BEGIN)
							state <= DROP;
						else
							state <= SPEC;
					end
				SPEC:
					if (udp_rx.data_valid)
						state <= full_word ? LIMITS : DROP;
				LIMITS:
					if (udp_rx.data_valid)
						state <= full_word ? MODE : DROP;
				MODE:
					if (udp_rx.data_valid) begin
						state     <= full_word ? EPHEMERAL : DROP;
						eph_count <= '0;
					end
				EPHEMERAL:
					if (udp_rx.data_valid) begin
						// Last ephemeral word holds the final three bytes
						if (eph_count == LAST_EPH_WORD)
							state <= (udp_rx.bytes_valid == 3'd3) ? DONE : DROP;
						else if (!full_word)
							state <= DROP;
						eph_count <= eph_count + 3'd1;
					end
				DONE:
					// Extra data means an over-long frame
					if (udp_rx.data_valid)
						state <= DROP;
				default: ;
			endcase

			// End of frame from the bus
			if (udp_rx.commit || udp_rx.drop)
				state <= IDLE;
			if (udp_rx.commit && state == DONE)
				req_valid <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Field capture

	always_ff @(posedge clk) begin
		if (udp_rx.data_valid) begin
			case (state)
				FIRST: begin
					req.version        <= udp_rx.data[23:8];
					req.ephemeral_mode <= ssp21_ephemeral_mode_t'(udp_rx.data[7:0]);
				end
				SPEC: begin
					req.hash         <= ssp21_hash_t'(udp_rx.data[31:24]);
					req.kdf          <= ssp21_kdf_t'(udp_rx.data[23:16]);
					req.nonce_mode   <= ssp21_nonce_mode_t'(udp_rx.data[15:8]);
					req.session_mode <= ssp21_session_mode_t'(udp_rx.data[7:0]);
				end
				LIMITS: begin
					req.max_nonce          <= udp_rx.data[31:16];
					req.max_session[31:16] <= udp_rx.data[15:0];
				end
				MODE: begin
					// Low byte is the first ephemeral byte, only counted
					req.max_session[15:0] <= udp_rx.data[31:16];
					req.handshake_mode    <= ssp21_handshake_mode_t'(udp_rx.data[15:8]);
				end
				default: ;
			endcase
		end
	end

endmodule

//--- design/ssp21_responder.sv
module ssp21_responder #(
	parameter ssp21_pkg::max_nonce_t   MAX_NONCE_LIMIT   = 16'd4096,
	parameter ssp21_pkg::session_dur_t MAX_SESSION_LIMIT = 32'd3600000
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  ssp21_pkg::ssp21_handshake_mode_t handshake_mode,
	input  ssp21_pkg::udp_rx_bus_t           udp_rx,
	output ssp21_pkg::udp_tx_bus_t           udp_tx
);
	import ssp21_pkg::*;

	// Parser to checker
	hs_request_t  req;
	logic         req_valid;

	// Checker to writers
	hs_session_t  session;
	logic         accept;
	logic         refuse;
	ssp21_error_t error_code;

	// Writers to arbiter
	logic         reply_req;
	logic         error_req;
	logic         reply_grant;
	logic         error_grant;
	tx_word_t     reply_word;
	tx_word_t     error_word;

	//////////////////////////////////////////////////
	// Receive side

	ssp21_request_parser parser_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.udp_rx    (udp_rx),
		.req       (req),
		.req_valid (req_valid)
	);

	ssp21_request_checker #(
		.MAX_NONCE_LIMIT   (MAX_NONCE_LIMIT),
		.MAX_SESSION_LIMIT (MAX_SESSION_LIMIT)
	) checker_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.handshake_mode (handshake_mode),
		.req            (req),
		.req_valid      (req_valid),
		.session        (session),
		.accept         (accept),
		.refuse         (refuse),
		.error_code     (error_code)
	);

	//////////////////////////////////////////////////
	// Reply side

	ssp21_reply_writer reply_writer_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.session (session),
		.accept  (accept),
		.grant   (reply_grant),
		.bus_req (reply_req),
		.tx_word (reply_word)
	);

	ssp21_error_writer error_writer_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.error_code (error_code),
		.refuse     (refuse),
		.grant      (error_grant),
		.bus_req    (error_req),
		.tx_word    (error_word)
	);

	udp_tx_arbiter arbiter_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.reply_req   (reply_req),
		.error_req   (error_req),
		.reply_word  (reply_word),
		.error_word  (error_word),
		.reply_grant (reply_grant),
		.error_grant (error_grant),
		.udp_tx      (udp_tx)
	);

endmodule

//--- design/udp_tx_arbiter.sv
module udp_tx_arbiter (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   reply_req,
	input  logic                   error_req,
	input  ssp21_pkg::tx_word_t    reply_word,
	input  ssp21_pkg::tx_word_t    error_word,
	output logic                   reply_grant,
	output logic                   error_grant,
	output ssp21_pkg::udp_tx_bus_t udp_tx
);
	import ssp21_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		COMMIT
	} state_t;

	state_t   state;
	logic     error_owner;
	logic     granted;
	tx_word_t sel_word;

	//////////////////////////////////////////////////
	// Owner selection, held for a whole frame

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= IDLE;
			error_owner <= 1'b0;
		end else begin
			case (state)
				IDLE:
					if (error_req || reply_req) begin
						// Error replies go first
						error_owner <= error_req;
						state       <= START;
					end
				START:
					state <= DATA;
				DATA:
					if (sel_word.valid && sel_word.last)
						state <= COMMIT;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Grant spans start strobe and data, dropped at commit
	assign granted     = (state == START) || (state == DATA);
	assign reply_grant = granted && !error_owner;
	assign error_grant = granted && error_owner;

	assign sel_word = error_owner ? error_word : reply_word;

	//////////////////////////////////////////////////
	// Outgoing bus

	assign udp_tx.start       = (state == START);
	assign udp_tx.data_valid  = (state == DATA) && sel_word.valid;
	assign udp_tx.bytes_valid = sel_word.bytes_valid;
	assign udp_tx.data        = sel_word.data;
	assign udp_tx.commit      = (state == COMMIT);

endmodule

//--- project.f
design/ssp21_pkg.sv
design/ssp21_request_parser.sv
design/ssp21_request_checker.sv
design/ssp21_reply_writer.sv
design/ssp21_error_writer.sv
design/udp_tx_arbiter.sv
design/ssp21_responder.sv
bench/ssp21_responder_sva.sv
bench/ssp21_responder_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the responder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module ssp21_responder_tb \
	-f project.f \
	-o ssp21_responder_sim

./obj_dir/ssp21_responder_sim
